//--- sim.f
+incdir+include
rtl/reflet_pkg.sv
rtl/reflet_reset.sv
rtl/reflet_cpu.sv
rtl/reflet_inst_mem.sv
rtl/reflet_data_ram.sv
rtl/reflet_periph.sv
rtl/reflet_controller.sv
bench/tb_clock.sv
bench/reflet_chk.sv
bench/tb_reflet.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_reflet -f sim.f

out="$(./obj_dir/Vtb_reflet)"
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
    exit 0
fi
exit 1

//--- bench/tb_reflet.sv
//****************************************
// directed tests for the controller top
// loads a program per test, runs it to quit and checks gpo and debug
//****************************************
`timescale 1ns/10ps
`include "reflet_cfg.svh"

module tb_reflet;

    localparam int period_ns = 40;
    // covers the clear sweep, six program loads and their runs with margin
    localparam int watchdog_cycles = 20000;
    localparam int quit_limit = 4000;
    localparam logic [11:0] pg_id = 12'h800;
    localparam logic [11:0] pg_gpi_lo = 12'h808;
    localparam logic [11:0] pg_gpi_hi = 12'h809;
    localparam logic [11:0] pg_gpo_lo = 12'h80A;
    localparam logic [11:0] pg_gpo_hi = 12'h80B;
    localparam logic [11:0] pg_timer = 12'h810;

    logic                  clk;
    logic                  rst_n;
    logic                  rst_limited_n;
    reflet_pkg::prog_req_t prog;
    reflet_pkg::word_t     gpi;
    reflet_pkg::word_t     gpo;
    logic                  quit;
    logic                  debug;
    reflet_pkg::word_t     code [$];
    reflet_pkg::word_t     dbg_seen [$];
    logic [31:0]           lcg_state;
    int                    errors;
    int                    tests;
    int                    failed;

    tb_clock #(.period_ns(period_ns)) i_clock (.clk(clk));

    reflet_controller i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rst_limited_n (rst_limited_n),
        .prog          (prog),
        .gpi           (gpi),
        .gpo           (gpo),
        .quit          (quit),
        .debug         (debug)
    );

    // debug is high for exactly one cycle, so one falling edge sees it
    always @(negedge clk) begin
        if (debug) begin
            dbg_seen.push_back(gpo);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic emit(input reflet_pkg::opcode_t op, input logic [11:0] operand);
        code.push_back({op, operand});
    endtask

    task automatic report_value(input string what, input reflet_pkg::word_t got,
                                input reflet_pkg::word_t exp);
        errors++;
        $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!i_dut.inst_ready && n < 2 * `REFLET_INST_WORDS + 16) begin
            @(negedge clk);
            n++;
        end
        if (!i_dut.inst_ready) begin
            errors++;
            $display("instruction memory never became ready after reset");
        end
    endtask

    task automatic wait_quit();
        int n;
        n = 0;
        while (!quit && n < quit_limit) begin
            @(negedge clk);
            n++;
        end
        if (!quit) begin
            errors++;
            $display("program did not reach quit within %0d cycles", quit_limit);
        end
    endtask

    // cpu side stays in limited reset while the code is written
    task automatic load_and_run();
        step();
        rst_limited_n = 1'b0;
        foreach (code[i]) begin
            step();
            prog.we   = 1'b1;
            prog.addr = 7'(i);
            prog.data = code[i];
        end
        step();
        prog.we = 1'b0;
        dbg_seen.delete();
        step();
        rst_limited_n = 1'b1;
        wait_quit();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic hw_id_readback();
        int e0;
        e0 = errors;
        code.delete();
        emit(reflet_pkg::op_ld, pg_id);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (gpo !== {8'h00, `REFLET_HW_ID}) begin
            report_value("gpo after id read", gpo, {8'h00, `REFLET_HW_ID});
        end
        finish_test("hw_id", e0);
    endtask

    task automatic arith_results();
        int                e0;
        logic [31:0]       r;
        logic [11:0]       a;
        logic [11:0]       b;
        reflet_pkg::word_t res;
        reflet_pkg::word_t exp [2];
        e0 = errors;
        r = lcg_next();
        a = r[27:16];
        r = lcg_next();
        b = r[27:16];
        res = {4'h0, a} + {4'h0, b};
        res = res - {4'h0, b};
        // both gpo bytes take the low byte of the stored word
        exp[0] = {res[7:0], res[7:0]};
        res = {4'h0, a} & {4'h0, b};
        exp[1] = {res[7:0], res[7:0]};
        code.delete();
        emit(reflet_pkg::op_ldi, a);
        emit(reflet_pkg::op_st, 12'd0);
        emit(reflet_pkg::op_ldi, b);
        emit(reflet_pkg::op_st, 12'd1);
        emit(reflet_pkg::op_ld, 12'd0);
        emit(reflet_pkg::op_add, 12'd1);
        emit(reflet_pkg::op_sub, 12'd1);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_st, pg_gpo_hi);
        emit(reflet_pkg::op_dbg, 12'h000);
        emit(reflet_pkg::op_ld, 12'd0);
        emit(reflet_pkg::op_and, 12'd1);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_st, pg_gpo_hi);
        emit(reflet_pkg::op_dbg, 12'h000);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (dbg_seen.size() != 2) begin
            errors++;
            $display("[FAIL] %0d ns: arith program gave %0d debug pulses, expected 2",
                     $time, dbg_seen.size());
        end else begin
            if (dbg_seen[0] !== exp[0]) begin
                report_value("gpo for (a+b)-b", dbg_seen[0], exp[0]);
            end
            if (dbg_seen[1] !== exp[1]) begin
                report_value("gpo for a and b", dbg_seen[1], exp[1]);
            end
        end
        finish_test("arith", e0);
    endtask

    task automatic countdown_branch();
        int          e0;
        logic [31:0] r;
        logic [11:0] n;
        e0 = errors;
        r = lcg_next();
        n = 12'(1 + (r[23:16] % 15));
        code.delete();
        // word 0 counts down, word 1 holds one, word 2 counts the passes
        emit(reflet_pkg::op_ldi, 12'd1);
        emit(reflet_pkg::op_st, 12'd1);
        emit(reflet_pkg::op_ldi, 12'd0);
        emit(reflet_pkg::op_st, 12'd2);
        emit(reflet_pkg::op_ldi, n);
        emit(reflet_pkg::op_st, 12'd0);
        emit(reflet_pkg::op_ld, 12'd0);
        emit(reflet_pkg::op_jz, 12'd15);
        emit(reflet_pkg::op_sub, 12'd1);
        emit(reflet_pkg::op_st, 12'd0);
        emit(reflet_pkg::op_ld, 12'd2);
        emit(reflet_pkg::op_add, 12'd1);
        emit(reflet_pkg::op_st, 12'd2);
        emit(reflet_pkg::op_dbg, 12'h000);
        emit(reflet_pkg::op_jmp, 12'd6);
        emit(reflet_pkg::op_ld, 12'd2);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (gpo !== {4'h0, n}) begin
            report_value("gpo after countdown", gpo, {4'h0, n});
        end
        if (dbg_seen.size() != int'(n)) begin
            errors++;
            $display("[FAIL] %0d ns: countdown gave %0d debug pulses, expected %0d",
                     $time, dbg_seen.size(), n);
        end
        finish_test("branch", e0);
    endtask

    task automatic gpio_echo();
        int          e0;
        logic [31:0] r;
        e0 = errors;
        r = lcg_next();
        step();
        gpi = r[31:16];
        code.delete();
        emit(reflet_pkg::op_ld, pg_gpi_lo);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_ld, pg_gpi_hi);
        emit(reflet_pkg::op_st, pg_gpo_hi);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (gpo !== gpi) begin
            report_value("gpo echo of gpi", gpo, gpi);
        end
        finish_test("gpio", e0);
    endtask

    task automatic timer_delay();
        int          e0;
        logic [31:0] r;
        int          loops;
        int          ticks_lo;
        e0 = errors;
        r = lcg_next();
        loops = 8 + int'(r[18:16]);
        // each pass is ld, jz, sub, st and jmp, 18 cycles
        // then the exit ld and jz and the fetch and decode of the timer read
        // prescaler phase at the clear is free, so one tick of slack
        ticks_lo = (18 * loops + 9) / `REFLET_TIMER_PRESCALE;
        code.delete();
        emit(reflet_pkg::op_ldi, 12'd1);
        emit(reflet_pkg::op_st, 12'd1);
        emit(reflet_pkg::op_ldi, 12'(loops));
        emit(reflet_pkg::op_st, 12'd0);
        emit(reflet_pkg::op_st, pg_timer);
        // delay loop at word 5, exit to word 10
        emit(reflet_pkg::op_ld, 12'd0);
        emit(reflet_pkg::op_jz, 12'd10);
        emit(reflet_pkg::op_sub, 12'd1);
        emit(reflet_pkg::op_st, 12'd0);
        emit(reflet_pkg::op_jmp, 12'd5);
        emit(reflet_pkg::op_ld, pg_timer);
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (gpo < 16'(ticks_lo) || gpo > 16'(ticks_lo + 1)) begin
            errors++;
            $display("[FAIL] %0d ns: timer read gave gpo %h, expected %h or %h",
                     $time, gpo, 16'(ticks_lo), 16'(ticks_lo + 1));
        end
        finish_test("timer", e0);
    endtask

    task automatic limited_reset_rerun();
        int                e0;
        logic [31:0]       r;
        reflet_pkg::word_t exp;
        e0 = errors;
        r = lcg_next();
        exp = r[31:16];
        code.delete();
        emit(reflet_pkg::op_ldi, {4'h0, exp[7:0]});
        emit(reflet_pkg::op_st, pg_gpo_lo);
        emit(reflet_pkg::op_ldi, {4'h0, exp[15:8]});
        emit(reflet_pkg::op_st, pg_gpo_hi);
        emit(reflet_pkg::op_quit, 12'h000);
        load_and_run();
        if (gpo !== exp) begin
            report_value("gpo on first run", gpo, exp);
        end
        step();
        rst_limited_n = 1'b0;
        step();
        step();
        if (quit !== 1'b0 || gpo !== '0) begin
            errors++;
            $display("[FAIL] %0d ns: limited reset left quit %b and gpo %h",
                     $time, quit, gpo);
        end
        rst_limited_n = 1'b1;
        wait_quit();
        if (gpo !== exp) begin
            report_value("gpo on rerun", gpo, exp);
        end
        finish_test("limited_reset", e0);
    endtask

    initial begin
        rst_n         = 1'b0;
        rst_limited_n = 1'b0;
        prog          = '0;
        gpi           = '0;
        lcg_state     = 32'ha8300cb6;
        errors        = 0;
        tests         = 0;
        failed        = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait_ready();
        hw_id_readback();
        arith_results();
        countdown_branch();
        gpio_echo();
        timer_delay();
        limited_reset_rerun();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * period_ns);
        $display("watchdog expired after %0d clock periods", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- bench/reflet_chk.sv
//****************************************
// protocol assertions, bound into the controller top
//****************************************
`timescale 1ns/10ps

module reflet_chk (
    input logic                   clk,
    input logic                   rst_sys_n,
    input logic                   quit,
    input logic                   bus_we,
    input reflet_pkg::cpu_state_t state,
    input reflet_pkg::word_t      gpo
);

    // once set, quit only clears through a reset
    quit_sticky: assert property (@(posedge clk) $fell(quit) |-> !$past(rst_sys_n))
        else $error("quit dropped while the cpu was out of reset");

    // stores only happen in the mem cycle
    no_store_in_fetch: assert property (@(posedge clk)
        state == reflet_pkg::st_fetch |-> !bus_we)
        else $error("bus write strobe high during instruction fetch");

    gpo_cleared: assert property (@(posedge clk) !rst_sys_n |=> gpo == '0)
        else $error("gpo not zero while the system is in reset");

endmodule

bind reflet_controller reflet_chk i_chk (
    .clk       (clk),
    .rst_sys_n (rst_sys_n),
    .quit      (quit),
    .bus_we    (bus.we),
    .state     (i_cpu.state),
    .gpo       (gpo)
);

//--- bench/tb_clock.sv
//****************************************
// free-running testbench clock
//****************************************
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

endmodule

//--- rtl/reflet_controller.sv
//****************************************
// top of the 16-bit controller
// cpu, code and data memories and the peripheral page on one bus
//****************************************
`timescale 1ns/10ps

module reflet_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rst_limited_n,
    input  reflet_pkg::prog_req_t prog,
    input  reflet_pkg::word_t     gpi,
    output reflet_pkg::word_t     gpo,
    output logic                  quit,
    output logic                  debug
);

    logic                 rst_full_n;
    logic                 rst_sys_n;
    logic                 inst_ready;
    reflet_pkg::bus_req_t bus;
    reflet_pkg::word_t    cpu_rdata;
    reflet_pkg::word_t    rdata_inst;
    reflet_pkg::word_t    rdata_data;
    reflet_pkg::byte_t    rdata_periph;

    reflet_reset i_reset (
        .clk           (clk),
        .rst_n         (rst_n),
        .rst_limited_n (rst_limited_n),
        .inst_ready    (inst_ready),
        .rst_full_n    (rst_full_n),
        .rst_sys_n     (rst_sys_n)
    );

    reflet_cpu i_cpu (
        .clk   (clk),
        .rst_n (rst_sys_n),
        .rdata (cpu_rdata),
        .bus   (bus),
        .quit  (quit),
        .debug (debug)
    );

    // unselected slaves return zero, so the read data can be ORed
    assign cpu_rdata = rdata_inst | rdata_data | {8'h00, rdata_periph};

    // only the full reset touches the code memory
    reflet_inst_mem i_inst_mem (
        .clk        (clk),
        .rst_n      (rst_full_n),
        .bus        (bus),
        .prog       (prog),
        .rdata      (rdata_inst),
        .inst_ready (inst_ready)
    );

    reflet_data_ram i_data_ram (
        .clk   (clk),
        .rst_n (rst_sys_n),
        .bus   (bus),
        .rdata (rdata_data)
    );

    reflet_periph i_periph (
        .clk   (clk),
        .rst_n (rst_sys_n),
        .bus   (bus),
        .gpi   (gpi),
        .gpo   (gpo),
        .rdata (rdata_periph)
    );

endmodule

//--- rtl/reflet_periph.sv
//****************************************
// 8-bit peripheral page at 0xFF00-0xFFFF
// hardware id, gpio and a prescaled timer
//****************************************
`timescale 1ns/10ps
`include "reflet_cfg.svh"

module reflet_periph (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reflet_pkg::bus_req_t bus,
    input  reflet_pkg::word_t    gpi,
    output reflet_pkg::word_t    gpo,
    output reflet_pkg::byte_t    rdata
);

    localparam int prescale = `REFLET_TIMER_PRESCALE;
    localparam int pw = (prescale > 1) ? $clog2(prescale) : 1;

    logic              sel;
    logic              wr;
    reflet_pkg::byte_t off;
    reflet_pkg::byte_t rd_mux;
    reflet_pkg::byte_t timer;
    logic [pw-1:0]     pre_cnt;
    logic              tick;

    assign sel = (bus.addr[15:8] == 8'hFF);
    assign off = bus.addr[7:0];
    assign wr  = sel && bus.we;

    // gpo bytes are written separately
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpo <= '0;
        end else if (wr && off == 8'h0A) begin
            gpo[7:0] <= bus.wdata[7:0];
        end else if (wr && off == 8'h0B) begin
            gpo[15:8] <= bus.wdata[7:0];
        end
    end

    assign tick = (pre_cnt == pw'(prescale - 1));

    // 8-bit count wraps on its own after 255
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            timer   <= '0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (wr && off == 8'h10) begin
                timer <= '0;
            end else if (tick) begin
                timer <= timer + 8'd1;
            end
        end
    end

    always_comb begin
        case (off)
            8'h00:   rd_mux = `REFLET_HW_ID;
            8'h08:   rd_mux = gpi[7:0];
            8'h09:   rd_mux = gpi[15:8];
            8'h0A:   rd_mux = gpo[7:0];
            8'h0B:   rd_mux = gpo[15:8];
            8'h10:   rd_mux = timer;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rdata <= sel ? rd_mux : '0;
    end

endmodule

//--- rtl/reflet_data_ram.sv
//****************************************
// data ram at 0x8000-0xFEFF, registered read
//****************************************
`timescale 1ns/10ps
`include "reflet_cfg.svh"

module reflet_data_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reflet_pkg::bus_req_t bus,
    output reflet_pkg::word_t    rdata
);

    localparam int depth = `REFLET_DATA_WORDS;
    localparam int aw = $clog2(depth);

    reflet_pkg::word_t mem [depth];
    logic [13:0]       word_idx;
    logic              sel;

    assign word_idx = bus.addr[14:1];

    // words past the depth are not backed and read as zero
    assign sel = bus.addr[15] && (bus.addr < 16'hFF00) && (word_idx < 14'(depth));

    always_ff @(posedge clk) begin
        if (rst_n && sel && bus.we) begin
            mem[word_idx[aw-1:0]] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= sel ? mem[word_idx[aw-1:0]] : '0;
    end

endmodule

//--- rtl/reflet_inst_mem.sv
//****************************************
// instruction ram at 0x0000-0x7FFF
// loaded through the program port, optional clear after full reset
//****************************************
`timescale 1ns/10ps
`include "reflet_cfg.svh"

module reflet_inst_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reflet_pkg::bus_req_t  bus,
    input  reflet_pkg::prog_req_t prog,
    output reflet_pkg::word_t     rdata,
    output logic                  inst_ready
);

    localparam int depth = `REFLET_INST_WORDS;
    localparam int aw = $clog2(depth);
    localparam bit mem_clear = (`REFLET_MEM_CLEAR != 0);

    reflet_pkg::word_t mem [depth];
    logic [aw-1:0]     clr_addr;
    logic              clearing;
    logic              sel;

    assign sel = !bus.addr[15];

    // clear sweep walks every word once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clearing   <= mem_clear;
            clr_addr   <= '0;
            inst_ready <= !mem_clear;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == aw'(depth - 1)) begin
                clearing   <= 1'b0;
                inst_ready <= 1'b1;
            end
        end
    end

    // sweep wins over the load port, load port over cpu stores
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= '0;
        end else if (prog.we) begin
            mem[prog.addr] <= prog.data;
        end else if (sel && bus.we) begin
            mem[bus.addr[aw:1]] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= sel ? mem[bus.addr[aw:1]] : '0;
    end

endmodule

//--- rtl/reflet_cpu.sv
//****************************************
// multi-cycle accumulator cpu
// fetch, decode, exec and an extra mem cycle for memory operands
//****************************************
`timescale 1ns/10ps

module reflet_cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reflet_pkg::word_t    rdata,
    output reflet_pkg::bus_req_t bus,
    output logic                 quit,
    output logic                 debug
);

    reflet_pkg::cpu_state_t state;
    reflet_pkg::word_t      ir;
    reflet_pkg::word_t      acc;
    reflet_pkg::opcode_t    op;
    reflet_pkg::addr_t      data_addr;
    logic [14:0]            pc;
    logic [14:0]            target;
    logic [11:0]            operand;
    logic                   mem_op;
    logic                   mem_phase;

    assign op      = reflet_pkg::opcode_t'(ir[15:12]);
    assign operand = ir[11:0];
    assign target  = {3'b000, operand};

    // bit 11 picks the peripheral page, otherwise a data ram word
    assign data_addr = operand[11] ? {8'hFF, operand[7:0]}
                                   : {4'b1000, operand[10:0], 1'b0};

    always_comb begin
        case (op)
            reflet_pkg::op_ld,
            reflet_pkg::op_st,
            reflet_pkg::op_add,
            reflet_pkg::op_sub,
            reflet_pkg::op_and: mem_op = 1'b1;
            default:            mem_op = 1'b0;
        endcase
    end

    assign mem_phase = (state == reflet_pkg::st_exec) || (state == reflet_pkg::st_mem);

    // address held through exec and mem, store strobe only in mem
    always_comb begin
        bus.addr  = {pc, 1'b0};
        bus.wdata = acc;
        bus.we    = 1'b0;
        if (mem_phase && mem_op) begin
            bus.addr = data_addr;
            bus.we   = (state == reflet_pkg::st_mem) && (op == reflet_pkg::op_st);
        end
    end

    // instruction word arrives one cycle after the fetch address
    always_ff @(posedge clk) begin
        if (state == reflet_pkg::st_decode) begin
            ir <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= reflet_pkg::st_fetch;
            pc    <= '0;
            acc   <= '0;
            quit  <= 1'b0;
            debug <= 1'b0;
        end else begin
            debug <= 1'b0;
            case (state)
                reflet_pkg::st_fetch: begin
                    state <= reflet_pkg::st_decode;
                end
                reflet_pkg::st_decode: begin
                    state <= reflet_pkg::st_exec;
                end
                reflet_pkg::st_exec: begin
                    state <= reflet_pkg::st_fetch;
                    pc    <= pc + 15'd1;
                    case (op)
                        reflet_pkg::op_ldi: begin
                            acc <= {4'h0, operand};
                        end
                        reflet_pkg::op_jmp: begin
                            pc <= target;
                        end
                        reflet_pkg::op_jz: begin
                            if (acc == '0) begin
                                pc <= target;
                            end
                        end
                        reflet_pkg::op_dbg: begin
                            debug <= 1'b1;
                        end
                        reflet_pkg::op_quit: begin
                            quit  <= 1'b1;
                            state <= reflet_pkg::st_halt;
                        end
                        default: begin
                            if (mem_op) begin
                                state <= reflet_pkg::st_mem;
                            end
                        end
                    endcase
                end
                reflet_pkg::st_mem: begin
                    // read data of the operand address is valid here
                    state <= reflet_pkg::st_fetch;
                    case (op)
                        reflet_pkg::op_ld:  acc <= rdata;
                        reflet_pkg::op_add: acc <= acc + rdata;
                        reflet_pkg::op_sub: acc <= acc - rdata;
                        reflet_pkg::op_and: acc <= acc & rdata;
                        default:            acc <= acc;
                    endcase
                end
                default: begin
                    // halted until the next reset
                    state <= reflet_pkg::st_halt;
                end
            endcase
        end
    end

endmodule

//--- rtl/reflet_reset.sv
//****************************************
// reset bootstrap and reset level combiner
//****************************************
`timescale 1ns/10ps

module reflet_reset (
    input  logic clk,
    input  logic rst_n,
    input  logic rst_limited_n,
    input  logic inst_ready,
    output logic rst_full_n,
    output logic rst_sys_n
);

    // starts low at power-up and rises on the first edge
    logic boot_done = 1'b0;

    always_ff @(posedge clk) begin
        boot_done <= 1'b1;
    end

    // full reset also covers the bootstrap cycle
    assign rst_full_n = rst_n & boot_done;

    // system reset keeps the cpu side held until the code memory is usable
    assign rst_sys_n = rst_full_n & rst_limited_n & inst_ready;

endmodule

//--- rtl/reflet_pkg.sv
//****************************************
// shared types of the controller
// referenced by scoped name from rtl and bench
//****************************************
`include "reflet_cfg.svh"

package reflet_pkg;

    typedef logic [`REFLET_WORD-1:0] word_t;
    typedef logic [15:0]             addr_t;
    typedef logic [7:0]              byte_t;

    // opcode sits in instruction bits 15:12
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_ldi  = 4'd1,
        op_ld   = 4'd2,
        op_st   = 4'd3,
        op_add  = 4'd4,
        op_sub  = 4'd5,
        op_and  = 4'd6,
        op_jmp  = 4'd7,
        op_jz   = 4'd8,
        op_dbg  = 4'd9,
        op_quit = 4'd10
    } opcode_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_halt
    } cpu_state_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

    // program load port into instruction memory
    typedef struct packed {
        logic                                  we;
        logic [$clog2(`REFLET_INST_WORDS)-1:0] addr;
        word_t                                 data;
    } prog_req_t;

endpackage

//--- include/reflet_cfg.svh
//****************************************
// build-time settings of the controller
// include wherever a size or option is needed
//****************************************
`ifndef REFLET_CFG_SVH
`define REFLET_CFG_SVH

// data word width in bits
`define REFLET_WORD 16

// memory depths in words
`define REFLET_INST_WORDS 128
`define REFLET_DATA_WORDS 100

// clock cycles per timer tick
`define REFLET_TIMER_PRESCALE 4

// value read back at peripheral offset 0x00
`define REFLET_HW_ID 8'h5A

// 1 makes the instruction memory zero itself after a full reset
`define REFLET_MEM_CLEAR 1

`endif
